/* source/memCtrl_config.svh */
`ifndef MEM_CTRL_CONFIG_SVH
`define MEM_CTRL_CONFIG_SVH

// byte address into the shared RAM
`define MEM_ADDR_WIDTH 17

`define MEM_DATA_WIDTH 32
`define MEM_BYTE_WIDTH 8

// one byte per address
`define MEM_DEPTH (1 << `MEM_ADDR_WIDTH)

// instruction fetch is always one full word
`define MEM_FETCH_LEN 4

`endif

/* source/memPkg.sv */
`default_nettype none

package memPkg;

    // what a granted request does on the RAM
    typedef enum logic [1:0] {
        ACCESS_FETCH = 2'd0,
        ACCESS_LOAD  = 2'd1,
        ACCESS_STORE = 2'd2
    } accessKind_e;

    // who currently holds the RAM
    typedef enum logic [1:0] {
        OWNER_NONE  = 2'd0,
        OWNER_DATA  = 2'd1,
        OWNER_FETCH = 2'd2
    } owner_e;

    // byte count, 1, 2 or 4
    typedef logic [2:0] accessLen_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_BUSY = 1'b1
    } seqState_e;

endpackage

`default_nettype wire

/* source/ramBusIf.sv */
`default_nettype none

`include "memCtrl_config.svh"

interface ramBusIf;

    logic                       en;
    logic                       we;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`MEM_BYTE_WIDTH-1:0] wdata;
    // one cycle after a read enable
    logic [`MEM_BYTE_WIDTH-1:0] rdata;

    modport seq (
        output en, we, addr, wdata,
        input  rdata
    );

    modport ram (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* source/memReqIf.sv */
`default_nettype none

`include "memCtrl_config.svh"

interface memReqIf;

    import memPkg::*;

    // operands hold steady from start until done
    logic                       start;
    accessKind_e                kind;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    accessLen_t                 len;
    logic [`MEM_DATA_WIDTH-1:0] wdata;

    logic                       busy;
    logic                       done;
    // assembled load word, only meaningful with done
    logic [`MEM_DATA_WIDTH-1:0] rdata;

    modport arb (
        output start, kind, addr, len, wdata,
        input  busy, done, rdata
    );

    modport seq (
        input  start, kind, addr, len, wdata,
        output busy, done, rdata
    );

endinterface

`default_nettype wire

/* source/memArbiter.sv */
`default_nettype none

`include "memCtrl_config.svh"

module memArbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_stall,

    input  logic                       i_fetchEn,
    input  logic [`MEM_ADDR_WIDTH-1:0] i_fetchAddr,

    input  logic                       i_dataEn,
    input  memPkg::accessKind_e        i_dataKind,
    input  memPkg::accessLen_t         i_dataLen,
    input  logic [`MEM_ADDR_WIDTH-1:0] i_dataAddr,
    input  logic [`MEM_DATA_WIDTH-1:0] i_dataWdata,

    output logic                       o_fetchDone,
    output logic [`MEM_DATA_WIDTH-1:0] o_fetchInst,
    output logic                       o_dataDone,
    output logic [`MEM_DATA_WIDTH-1:0] o_dataRdata,
    output memPkg::owner_e             o_owner,

    memReqIf.arb                       req
);

    import memPkg::*;

    seqState_e state;
    owner_e    owner;
    logic      grant;

    // free RAM and an idle sequencer
    assign grant = !i_stall && state == SEQ_IDLE && !req.busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            owner     <= OWNER_NONE;
            req.start <= 1'b0;
        end else if (!i_stall) begin
            req.start <= 1'b0;
            if (grant) begin
                // data side first
                if (i_dataEn) begin
                    req.start <= 1'b1;
                    state     <= SEQ_BUSY;
                    owner     <= OWNER_DATA;
                end else if (i_fetchEn) begin
                    req.start <= 1'b1;
                    state     <= SEQ_BUSY;
                    owner     <= OWNER_FETCH;
                end
            end else if (req.done) begin
                state <= SEQ_IDLE;
                owner <= OWNER_NONE;
            end
        end
    end

    // request operands latched at grant
    always_ff @(posedge clk) begin
        if (grant) begin
            if (i_dataEn) begin
                req.kind  <= i_dataKind;
                req.addr  <= i_dataAddr;
                req.len   <= i_dataLen;
                req.wdata <= i_dataWdata;
            end else if (i_fetchEn) begin
                req.kind  <= ACCESS_FETCH;
                req.addr  <= i_fetchAddr;
                req.len   <= accessLen_t'(`MEM_FETCH_LEN);
                req.wdata <= '0;
            end
        end
    end

    // completion goes back to whoever owns the RAM
    assign o_dataDone  = req.done && owner == OWNER_DATA;
    assign o_fetchDone = req.done && owner == OWNER_FETCH;

    assign o_dataRdata = (o_dataDone && req.kind == ACCESS_LOAD) ? req.rdata : '0;
    assign o_fetchInst = o_fetchDone ? req.rdata : '0;

    assign o_owner = owner;

endmodule

`default_nettype wire

/* source/byteSequencer.sv */
`default_nettype none

`include "memCtrl_config.svh"

module byteSequencer (
    input  logic clk,
    input  logic rst,
    input  logic i_stall,
    memReqIf.seq req,
    ramBusIf.seq ram
);

    import memPkg::*;

    localparam int AddrW = `MEM_ADDR_WIDTH;
    localparam int ByteW = `MEM_BYTE_WIDTH;

    seqState_e                  state;
    logic [2:0]                 step;
    logic [1:0]                 prevLane;
    logic                       isStore;
    logic                       lastStep;
    logic                       issue;
    logic [`MEM_DATA_WIDTH-1:0] wordQ;
    logic [`MEM_DATA_WIDTH-1:0] word;

    assign isStore = req.kind == ACCESS_STORE;

    // lane of the byte now on the RAM read port
    assign prevLane = 2'(step - 3'd1);

    // loads need one extra step to catch the last byte
    always_comb begin
        if (isStore) begin
            lastStep = step == 3'(req.len - 3'd1);
        end else begin
            lastStep = step == req.len;
        end
    end

    assign issue = state == SEQ_BUSY && !i_stall && step < req.len;

    assign ram.en    = issue;
    assign ram.we    = issue && isStore;
    assign ram.addr  = req.addr + AddrW'(step);
    assign ram.wdata = req.wdata[step[1:0]*ByteW +: ByteW];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            step  <= 3'd0;
        end else if (!i_stall) begin
            case (state)
                SEQ_IDLE: begin
                    if (req.start) begin
                        state <= SEQ_BUSY;
                        step  <= 3'd0;
                    end
                end
                SEQ_BUSY: begin
                    if (lastStep) begin
                        state <= SEQ_IDLE;
                        step  <= 3'd0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // collected load bytes, cleared so short loads come back zero-filled
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            if (state == SEQ_IDLE && req.start) begin
                wordQ <= '0;
            end else if (state == SEQ_BUSY && !isStore && step != 3'd0) begin
                wordQ[prevLane*ByteW +: ByteW] <= ram.rdata;
            end
        end
    end

    // last byte goes straight from the RAM into its lane
    always_comb begin
        word = wordQ;
        word[prevLane*ByteW +: ByteW] = ram.rdata;
    end

    assign req.busy  = state == SEQ_BUSY;
    assign req.done  = state == SEQ_BUSY && !i_stall && lastStep;
    assign req.rdata = word;

endmodule

`default_nettype wire

/* source/byteRam.sv */
`default_nettype none

`include "memCtrl_config.svh"

module byteRam (
    input  logic clk,
    ramBusIf.ram ram
);

    logic [`MEM_BYTE_WIDTH-1:0] mem [`MEM_DEPTH];
    logic [`MEM_BYTE_WIDTH-1:0] rdataQ;

    // single port, write or read per enabled cycle
    always_ff @(posedge clk) begin
        if (ram.en) begin
            if (ram.we) begin
                mem[ram.addr] <= ram.wdata;
            end else begin
                rdataQ <= mem[ram.addr];
            end
        end
    end

    // holds the last read while idle
    assign ram.rdata = rdataQ;

endmodule

`default_nettype wire

/* source/memSubsystem.sv */
`default_nettype none

`include "memCtrl_config.svh"

module memSubsystem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_rdy,
    input  logic                       i_ioBufferFull,

    input  logic                       i_fetchEn,
    input  logic [`MEM_ADDR_WIDTH-1:0] i_fetchAddr,

    input  logic                       i_dataEn,
    input  memPkg::accessKind_e        i_dataKind,
    input  memPkg::accessLen_t         i_dataLen,
    input  logic [`MEM_ADDR_WIDTH-1:0] i_dataAddr,
    input  logic [`MEM_DATA_WIDTH-1:0] i_dataWdata,

    output logic                       o_fetchDone,
    output logic [`MEM_DATA_WIDTH-1:0] o_fetchInst,
    output logic                       o_dataDone,
    output logic [`MEM_DATA_WIDTH-1:0] o_dataRdata,
    output memPkg::owner_e             o_owner
);

    logic stall;

    // core not ready or I/O buffer full freezes everything
    assign stall = !i_rdy || i_ioBufferFull;

    memReqIf reqBus ();
    ramBusIf ramBus ();

    memArbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (stall),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataKind  (i_dataKind),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .o_owner     (o_owner),
        .req         (reqBus.arb)
    );

    byteSequencer sequencer_i (
        .clk     (clk),
        .rst     (rst),
        .i_stall (stall),
        .req     (reqBus.seq),
        .ram     (ramBus.seq)
    );

    byteRam ram_i (
        .clk (clk),
        .ram (ramBus.ram)
    );

endmodule

`default_nettype wire

/* verif/clkGen.sv */
`default_nettype none

module clkGen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod = 2;
    localparam int ResetCycles = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #HalfPeriod;
            clk = ~clk;
        end
    end

    // released on a falling edge, after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/memSubsystemTb.sv */
`default_nettype none

`include "memCtrl_config.svh"

module memSubsystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    import memPkg::*;

    localparam int AddrW = `MEM_ADDR_WIDTH;
    localparam int NumTests = 19;
    localparam int CyclesPerTest = 40;
    localparam int ClkPeriod = 4;

    // where the stall of an entry comes from
    localparam logic [1:0] NoStall = 2'd0;
    localparam logic [1:0] RdyLow = 2'd1;
    localparam logic [1:0] IoFull = 2'd2;

    typedef struct packed {
        accessKind_e                kind;
        logic [AddrW-1:0]           addr;
        accessLen_t                 len;
        logic [`MEM_DATA_WIDTH-1:0] wdata;
        // write word drawn from the LFSR
        logic                       rndData;
        logic                       withFetch;
        logic [AddrW-1:0]           fetchAddr;
        logic [1:0]                 stall;
    } entry_t;

    logic                       clk;
    logic                       rst;
    logic                       i_rdy;
    logic                       i_ioBufferFull;
    logic                       i_fetchEn;
    logic [AddrW-1:0]           i_fetchAddr;
    logic                       i_dataEn;
    accessKind_e                i_dataKind;
    accessLen_t                 i_dataLen;
    logic [AddrW-1:0]           i_dataAddr;
    logic [`MEM_DATA_WIDTH-1:0] i_dataWdata;
    logic                       o_fetchDone;
    logic [`MEM_DATA_WIDTH-1:0] o_fetchInst;
    logic                       o_dataDone;
    logic [`MEM_DATA_WIDTH-1:0] o_dataRdata;
    owner_e                     o_owner;

    entry_t      tests [NumTests];
    bit [7:0]    model [`MEM_DEPTH];
    logic [15:0] lfsr;
    int          errors;
    int          testErrors;
    int          failedTests;

    clkGen clkGen_i (.clk(clk), .rst(rst));

    memSubsystem memSubsystem_i (.*);

    // galois form stepped once per bit handed out
    function automatic logic takeBit();
        logic b;
        b = lfsr[0];
        if (lfsr[0]) begin
            lfsr = (lfsr >> 1) ^ 16'hB400;
        end else begin
            lfsr = lfsr >> 1;
        end
        return b;
    endfunction

    function automatic logic [31:0] randWord();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w[i] = takeBit();
        end
        return w;
    endfunction

    // little-endian with upper bytes zero
    function automatic logic [31:0] modelWord(input logic [AddrW-1:0] a, input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i*8 +: 8] = model[a + AddrW'(i)];
        end
        return w;
    endfunction

    task automatic storeModel(input logic [AddrW-1:0] a, input int n, input logic [31:0] w);
        for (int i = 0; i < n; i++) begin
            model[a + AddrW'(i)] = w[i*8 +: 8];
        end
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        errors++;
        testErrors++;
    endtask

    task automatic runEntry(input int idx);
        entry_t           e;
        logic [31:0]      wdata;
        logic [31:0]      expData;
        logic [31:0]      expInst;
        logic [AddrW-1:0] instAddr;
        logic             dataOn;
        logic             fetchOn;
        logic             dataSeen;
        logic             fetchSeen;
        logic             stalled;
        logic             prevStalled;
        owner_e           prevOwner;
        owner_e           lastOwner;
        logic [31:0]      trace;
        logic [31:0]      expTrace;
        int               cyc;
        int               stalls;
        int               baseLat;
        e = tests[idx];
        testErrors = 0;
        dataOn = e.kind != ACCESS_FETCH;
        fetchOn = !dataOn || e.withFetch;
        instAddr = dataOn ? e.fetchAddr : e.addr;
        wdata = e.rndData ? randWord() : e.wdata;
        // data goes first and a fetch in the same entry sees this store
        if (e.kind == ACCESS_STORE) begin
            storeModel(e.addr, int'(e.len), wdata);
            expData = '0;
            baseLat = int'(e.len) + 1;
        end else begin
            expData = modelWord(e.addr, int'(e.len));
            baseLat = dataOn ? int'(e.len) + 2 : `MEM_FETCH_LEN + 2;
        end
        expInst = modelWord(instAddr, `MEM_FETCH_LEN);
        expTrace = '0;
        if (dataOn) begin
            expTrace = {expTrace[27:0], OWNER_DATA, OWNER_NONE};
        end
        if (fetchOn) begin
            expTrace = {expTrace[27:0], OWNER_FETCH, OWNER_NONE};
        end
        dataSeen = 1'b0;
        fetchSeen = 1'b0;
        prevStalled = 1'b0;
        prevOwner = OWNER_NONE;
        lastOwner = OWNER_NONE;
        trace = '0;
        cyc = 0;
        stalls = 0;
        while (((dataOn && !dataSeen) || (fetchOn && !fetchSeen)) && cyc < CyclesPerTest) begin
            @(negedge clk);
            i_dataEn = dataOn && !dataSeen;
            i_dataKind = e.kind;
            i_dataLen = e.len;
            i_dataAddr = e.addr;
            i_dataWdata = wdata;
            i_fetchEn = fetchOn && !fetchSeen;
            i_fetchAddr = instAddr;
            stalled = (e.stall != NoStall && cyc < 8) ? takeBit() : 1'b0;
            i_rdy = !(stalled && e.stall == RdyLow);
            i_ioBufferFull = stalled && e.stall == IoFull;
            // outputs have settled half way to the rising edge
            #1;
            if (prevStalled) begin
                checkEq(32'(o_owner), 32'(prevOwner), "owner across a stall");
            end
            if (o_owner != lastOwner) begin
                trace = {trace[29:0], o_owner};
                lastOwner = o_owner;
            end
            if (stalled) begin
                checkEq(32'(o_dataDone), 32'(0), "data done while stalled");
                checkEq(32'(o_fetchDone), 32'(0), "fetch done while stalled");
            end
            if (o_dataDone) begin
                if (!dataOn || dataSeen) begin
                    reportProblem($sformatf("test %0d: data done without a data request", idx));
                end else begin
                    checkEq(o_dataRdata, expData, "load data");
                    checkEq(cyc, baseLat + stalls, "data latency");
                    dataSeen = 1'b1;
                end
            end
            if (o_fetchDone) begin
                if (!fetchOn || fetchSeen) begin
                    reportProblem($sformatf("test %0d: fetch done without a fetch request", idx));
                end else begin
                    if (dataOn && !dataSeen) begin
                        reportProblem($sformatf("test %0d: fetch finished ahead of data", idx));
                    end
                    checkEq(o_fetchInst, expInst, "fetched instruction");
                    if (!dataOn) begin
                        checkEq(cyc, baseLat + stalls, "fetch latency");
                    end
                    fetchSeen = 1'b1;
                end
            end
            prevStalled = stalled;
            prevOwner = o_owner;
            if (stalled) begin
                stalls++;
            end
            cyc++;
        end
        if ((dataOn && !dataSeen) || (fetchOn && !fetchSeen)) begin
            reportProblem($sformatf("test %0d: a done pulse never arrived", idx));
        end
        @(negedge clk);
        i_dataEn = 1'b0;
        i_fetchEn = 1'b0;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        #1;
        checkEq(32'(o_dataDone), 32'(0), "data done after its pulse");
        checkEq(32'(o_fetchDone), 32'(0), "fetch done after its pulse");
        if (o_owner != lastOwner) begin
            trace = {trace[29:0], o_owner};
        end
        checkEq(trace, expTrace, "owner sequence");
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %0d %s addr %h len %0d: %s", idx, e.kind.name(), e.addr, e.len,
                 testErrors == 0 ? "ok" : "FAILED");
    endtask

    task automatic fillTable();
        tests[0]  = '{ACCESS_STORE, 17'h00100, 3'd4, 32'h44332211, 1'b0, 1'b0, 17'h0, NoStall};
        tests[1]  = '{ACCESS_LOAD,  17'h00100, 3'd4, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
        tests[2]  = '{ACCESS_LOAD,  17'h00102, 3'd2, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
        tests[3]  = '{ACCESS_LOAD,  17'h00101, 3'd1, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
        tests[4]  = '{ACCESS_STORE, 17'h00200, 3'd1, 32'h0, 1'b1, 1'b0, 17'h0, NoStall};
        tests[5]  = '{ACCESS_STORE, 17'h00201, 3'd1, 32'h0, 1'b1, 1'b0, 17'h0, NoStall};
        tests[6]  = '{ACCESS_STORE, 17'h00202, 3'd2, 32'h0, 1'b1, 1'b0, 17'h0, NoStall};
        tests[7]  = '{ACCESS_LOAD,  17'h00200, 3'd4, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
        tests[8]  = '{ACCESS_STORE, 17'h00300, 3'd2, 32'h0, 1'b1, 1'b0, 17'h0, RdyLow};
        tests[9]  = '{ACCESS_LOAD,  17'h00300, 3'd2, 32'h0, 1'b0, 1'b0, 17'h0, IoFull};
        tests[10] = '{ACCESS_STORE, 17'h00400, 3'd4, 32'h00100093, 1'b0, 1'b0, 17'h0, NoStall};
        tests[11] = '{ACCESS_STORE, 17'h00404, 3'd4, 32'h0, 1'b1, 1'b0, 17'h0, NoStall};
        tests[12] = '{ACCESS_FETCH, 17'h00400, 3'd4, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
        tests[13] = '{ACCESS_FETCH, 17'h00404, 3'd4, 32'h0, 1'b0, 1'b0, 17'h0, RdyLow};
        tests[14] = '{ACCESS_LOAD,  17'h00100, 3'd4, 32'h0, 1'b0, 1'b1, 17'h00400, NoStall};
        tests[15] = '{ACCESS_STORE, 17'h00500, 3'd4, 32'h0, 1'b1, 1'b1, 17'h00404, IoFull};
        tests[16] = '{ACCESS_LOAD,  17'h00500, 3'd4, 32'h0, 1'b0, 1'b0, 17'h0, RdyLow};
        tests[17] = '{ACCESS_STORE, 17'h1FFFF, 3'd1, 32'h0, 1'b1, 1'b0, 17'h0, IoFull};
        tests[18] = '{ACCESS_LOAD,  17'h1FFFF, 3'd1, 32'h0, 1'b0, 1'b0, 17'h0, NoStall};
    endtask

    initial begin
        lfsr = 16'd74;
        errors = 0;
        failedTests = 0;
        testErrors = 0;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchEn = 1'b0;
        i_fetchAddr = '0;
        i_dataEn = 1'b0;
        i_dataKind = ACCESS_LOAD;
        i_dataLen = '0;
        i_dataAddr = '0;
        i_dataWdata = '0;
        fillTable();
        // through reset and two cycles past it
        repeat (6) begin
            @(negedge clk);
            #1;
            checkEq(32'(o_dataDone), 32'(0), "data done around reset");
            checkEq(32'(o_fetchDone), 32'(0), "fetch done around reset");
            checkEq(32'(o_owner), 32'(OWNER_NONE), "owner around reset");
        end
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test reset: %s", testErrors == 0 ? "ok" : "FAILED");
        for (int i = 0; i < NumTests; i++) begin
            runEntry(i);
        end
        $display("%0d tests, %0d failed, %0d errors", NumTests + 1, failedTests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget per table entry plus the reset phase
    initial begin
        #((NumTests * CyclesPerTest + 20) * ClkPeriod);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/memPkg.sv
source/ramBusIf.sv
source/memReqIf.sv
source/memArbiter.sv
source/byteSequencer.sv
source/byteRam.sv
source/memSubsystem.sv
verif/clkGen.sv
verif/memSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= memSubsystemTb
RTL_TOP   ?= memSubsystem
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= sim passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
